//--- tb.f
common/rv_pkg.sv
src/regfile.sv
src/mem_arbiter.sv
src/fetch/fetch_unit.sv
src/decode/inst_decoder.sv
src/execute/exec_unit.sv
src/mem_stage/mem_stage.sv
src/rv_core_top.sv
tests/tb_top.sv

//--- Makefile
# Verilator simulation of the RV32I core

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- tests/tb_top.sv
// Testbench for the RV32I core
// Random program, memory model and ISA reference

`timescale 1ns/10ps

module tb_top import rv_pkg::*; ();
    localparam int NUM_RETIRES    = 2000;
    localparam int TIMEOUT_CYCLES = NUM_RETIRES * 12;   // Worst case is about 10 per retire
    localparam int MEM_WORDS      = 1024;
    localparam int CODE_END       = 895;   // Last code word, data lives above

    logic     clk = 1'b0;
    logic     reset;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    retire_t  retire;

    logic [31:0] lfsr;
    logic [31:0] dut_mem [MEM_WORDS];
    logic [31:0] ref_mem [MEM_WORDS];
    logic [31:0] ref_x [32];
    logic [31:0] ref_pc;
    logic        pend;
    mem_req_t    pend_req;
    int          delay_cnt;
    int          cycles;
    int          retires;
    int          idx;
    logic        seen_req;
    logic [31:0] e_pc;
    logic [31:0] e_wd;
    logic [4:0]  e_rd;
    logic        e_we;

    rv_core_top #(
        .RESET_PC(RESET_PC)
    ) dut0 (
        .clk,
        .reset,
        .mem_req,
        .mem_rsp,
        .retire
    );

    always #50 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [4:0] pick_rd();
        logic [4:0] r;
        r = 5'(rand_bits(5));
        return (r >= 5'd27) ? 5'd0 : r;   // x27..x31 reserved
    endfunction

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic load_program();
        int          i;
        logic [31:0] w;
        logic [31:0] r;
        logic [19:0] uimm;
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        for (int k = 0; k < MEM_WORDS; k++) begin
            dut_mem[k] = rand_bits(32);
        end
        dut_mem[0] = {20'h00001, 5'd28, OPC_LUI};
        dut_mem[1] = {12'hE00, 5'd28, 3'b000, 5'd28, OPC_OP_IMM};   // x28 = 0xE00
        dut_mem[2] = {12'd64, 5'd28, 3'b000, 5'd29, OPC_OP_IMM};
        dut_mem[3] = {12'd128, 5'd28, 3'b000, 5'd30, OPC_OP_IMM};
        dut_mem[4] = {12'd192, 5'd28, 3'b000, 5'd31, OPC_OP_IMM};
        i = 5;
        while (i < CODE_END) begin
            kind = 3'(rand_bits(3));
            if (i > CODE_END - 10) begin
                kind = 3'd1;   // Keep jumps inside the code area
            end
            rd  = pick_rd();
            rs1 = 5'(rand_bits(5));
            rs2 = 5'(rand_bits(5));
            f3  = 3'(rand_bits(3));
            r   = rand_bits(12);
            imm = {6'b0, r[5:0]};
            case (kind)
                3'd0: w = {1'b0, r[6] && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd, OPC_OP};
                3'd1: begin
                    imm = r[11:0];
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        imm[11:5] = {1'b0, r[6] && f3 == 3'd5, 5'b0};   // Shift encodings
                    end
                    w = {imm, rs1, f3, rd, OPC_OP_IMM};
                end
                3'd2: begin
                    if (f3 == 3'd3 || f3 >= 3'd6) begin
                        f3 = 3'd2;
                    end
                    w = {imm, 3'b111, r[7:6], f3, rd, OPC_LOAD};
                end
                3'd3: begin
                    f3 = (f3[1:0] == 2'd3) ? 3'd2 : {1'b0, f3[1:0]};
                    w  = {imm[11:5], rs2, 3'b111, r[7:6], f3, imm[4:0], OPC_STORE};
                end
                3'd4: begin
                    if (f3 == 3'd2 || f3 == 3'd3) begin
                        f3 = f3 + 3'd4;
                    end
                    boff = 13'(4 * (1 + r[1:0]));   // Forward only, no endless loops
                    w = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], OPC_BRANCH};
                end
                3'd5: begin
                    joff = 21'(4 * (1 + r[2:0]));
                    w = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
                end
                3'd6: begin
                    uimm = 20'(rand_bits(20));
                    w = {uimm, rd, r[0] ? OPC_LUI : OPC_AUIPC};
                end
                default: begin
                    // AUIPC x27 then JALR past itself, odd offsets test bit 0 clearing
                    dut_mem[i] = {20'b0, 5'd27, OPC_AUIPC};
                    i++;
                    imm = 12'(8 + 4 * r[1:0] + r[2]);
                    w = {imm, 5'd27, 3'b000, rd, OPC_JALR};
                end
            endcase
            dut_mem[i] = w;
            i++;
        end
        joff = -21'(CODE_END * 4);
        dut_mem[CODE_END] = {joff[20], joff[10:1], joff[11], joff[19:12], 5'd0, OPC_JAL};
        ref_mem = dut_mem;
    endtask

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic br_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Executes one instruction of the reference model
    task automatic ref_step(output logic [31:0] pc_o, output logic we_o,
                            output logic [4:0] rd_o, output logic [31:0] wd_o);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] addr;
        logic [31:0] ld;
        logic [31:0] sd;
        logic [31:0] res;
        logic [31:0] npc;
        logic [7:0]  mask;
        logic [2:0]  f3;
        w     = ref_mem[ref_pc[11:2]];
        f3    = w[14:12];
        a     = ref_x[w[19:15]];
        b     = ref_x[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        npc   = ref_pc + 4;
        pc_o  = ref_pc;
        rd_o  = w[11:7];
        we_o  = 1'b1;
        res   = '0;
        case (w[6:0])
            OPC_OP:     res = alu(f3, w[30], a, b);
            OPC_OP_IMM: res = alu(f3, w[30] && f3 == 3'd5, a, imm_i);
            OPC_LUI:    res = imm_u;
            OPC_AUIPC:  res = ref_pc + imm_u;
            OPC_JAL: begin
                res = ref_pc + 4;
                npc = ref_pc + imm_j;
            end
            OPC_JALR: begin
                res = ref_pc + 4;
                npc = (a + imm_i) & ~32'd1;
            end
            OPC_LOAD: begin
                addr = a + imm_i;
                ld   = ref_mem[addr[11:2]] >> (8 * addr[1:0]);
                case (f3)
                    3'd0:    res = {{24{ld[7]}}, ld[7:0]};
                    3'd1:    res = {{16{ld[15]}}, ld[15:0]};
                    3'd4:    res = {24'b0, ld[7:0]};
                    3'd5:    res = {16'b0, ld[15:0]};
                    default: res = ld;
                endcase
            end
            OPC_STORE: begin
                we_o = 1'b0;
                addr = a + imm_s;
                mask = {4'b0, (f3[1:0] == 2'd0) ? 4'h1 : (f3[1:0] == 2'd1) ? 4'h3 : 4'hF};
                mask = mask << addr[1:0];
                sd   = b << (8 * addr[1:0]);
                for (int k = 0; k < 4; k++) begin
                    if (mask[k]) begin
                        ref_mem[addr[11:2]][8*k +: 8] = sd[8*k +: 8];
                    end
                end
            end
            OPC_BRANCH: begin
                we_o = 1'b0;
                if (br_taken(f3, a, b)) begin
                    npc = ref_pc + imm_b;
                end
            end
            default: we_o = 1'b0;   // No-op
        endcase
        if (we_o && rd_o != 5'd0) begin
            ref_x[rd_o] = res;
        end
        wd_o   = res;
        ref_pc = npc;
    endtask

    // Memory responses, driven on the falling edge
    always @(negedge clk) begin
        mem_rsp = '0;
        if (pend) begin
            delay_cnt = delay_cnt - 1;
            if (delay_cnt == 0) begin
                pend = 1'b0;
                idx  = int'(pend_req.addr[11:2]);
                for (int k = 0; k < 4; k++) begin
                    if (pend_req.we && pend_req.wmask[k]) begin
                        dut_mem[idx][8*k +: 8] = pend_req.wdata[8*k +: 8];
                    end
                end
                mem_rsp.valid = 1'b1;
                mem_rsp.rdata = dut_mem[idx];
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: the core stopped retiring after %0d instructions", retires);
            stop_run();
        end
        if (reset) begin
            check_value("mem_req.valid", 32'(mem_req.valid), 32'd0);
            check_value("retire.valid", 32'(retire.valid), 32'd0);
        end else begin
            if (mem_req.valid) begin
                if (!seen_req) begin
                    check_value("mem_req.addr", mem_req.addr, RESET_PC);
                    seen_req = 1'b1;
                end
                if (pend) begin
                    $display("A memory request was issued while another one was outstanding");
                    stop_run();
                end
                pend      = 1'b1;
                pend_req  = mem_req;
                delay_cnt = 1 + int'(rand_bits(2));
            end
            if (retire.valid) begin
                ref_step(e_pc, e_we, e_rd, e_wd);
                check_value("retire.pc", retire.pc, e_pc);
                check_value("retire.we", 32'(retire.we), 32'(e_we));
                check_value("retire.rd", 32'(retire.rd), 32'(e_rd));
                if (e_we) begin
                    check_value("retire.wdata", retire.wdata, e_wd);
                end
                retires++;
            end
        end
    end

    initial begin
        reset    = 1'b1;
        mem_rsp  = '0;
        lfsr     = 32'hfa4cce8f;
        pend     = 1'b0;
        pend_req = '0;
        cycles   = 0;
        retires  = 0;
        seen_req = 1'b0;
        ref_pc   = RESET_PC;
        for (int k = 0; k < 32; k++) begin
            ref_x[k] = '0;
        end
        load_program();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait (retires == NUM_RETIRES);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- src/rv_core_top.sv
// Multi-cycle RV32I core

`timescale 1ns/10ps

module rv_core_top import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = rv_pkg::RESET_PC
) (
    input  logic     clk,
    input  logic     reset,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp,
    output retire_t  retire
);
    mem_req_t        fetch_req;
    mem_rsp_t        fetch_rsp;
    mem_req_t        data_req;
    mem_rsp_t        data_rsp;
    inst_u           inst;
    logic [XLEN-1:0] pc;
    logic            issue;
    decoded_t        dec;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] wb_data;
    logic            wb_en;
    logic [XLEN-1:0] exec_next_pc;
    logic [XLEN-1:0] next_pc;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk,
        .reset,
        .fetch_req,
        .fetch_rsp,
        .retire_valid(retire.valid),
        .next_pc,
        .inst,
        .pc,
        .issue
    );

    inst_decoder u_decoder (
        .inst,
        .dec
    );

    regfile u_regfile (
        .clk,
        .reset,
        .rs1   (dec.rs1),
        .rs2   (dec.rs2),
        .rdata1,
        .rdata2,
        .wr    (retire)
    );

    exec_unit u_exec (
        .dec,
        .pc,
        .rdata1,
        .rdata2,
        .alu_result,
        .wb_data,
        .wb_en,
        .next_pc(exec_next_pc)
    );

    mem_stage u_mem_stage (
        .clk,
        .reset,
        .issue,
        .dec,
        .pc,
        .addr      (alu_result),
        .store_data(rdata2),
        .wb_data,
        .wb_en,
        .next_pc_in(exec_next_pc),
        .mem_out   (data_req),
        .mem_in    (data_rsp),
        .retire,
        .next_pc
    );

    mem_arbiter u_arbiter (
        .clk,
        .reset,
        .fetch_req,
        .fetch_rsp,
        .data_req,
        .data_rsp,
        .mem_req,
        .mem_rsp
    );

endmodule

//--- src/mem_stage/mem_stage.sv
// Load/store access and retirement

`timescale 1ns/10ps

module mem_stage import rv_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            issue,
    input  decoded_t        dec,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] store_data,
    input  logic [XLEN-1:0] wb_data,
    input  logic            wb_en,
    input  logic [XLEN-1:0] next_pc_in,
    output mem_req_t        mem_out,
    input  mem_rsp_t        mem_in,
    output retire_t         retire,
    output logic [XLEN-1:0] next_pc
);
    logic            is_load;
    logic            is_store;
    logic            busy;
    logic [1:0]      offset;
    logic [3:0]      base_mask;
    logic [7:0]      wide_mask;
    logic [XLEN-1:0] load_shift;
    logic [XLEN-1:0] load_ext;

    assign is_load  = dec.opcode == OPC_LOAD;
    assign is_store = dec.opcode == OPC_STORE;
    assign offset   = addr[1:0];

    always_comb begin
        case (dec.funct3[1:0])
            2'b00:   base_mask = 4'b0001;
            2'b01:   base_mask = 4'b0011;
            default: base_mask = 4'b1111;
        endcase
    end

    assign wide_mask = {4'b0000, base_mask} << offset;  // Lanes past byte 3 drop out

    always_comb begin
        mem_out.valid = issue && (is_load || is_store);
        mem_out.we    = is_store;
        mem_out.addr  = {addr[XLEN-1:2], 2'b00};
        mem_out.wdata = store_data << {offset, 3'b000};
        mem_out.wmask = wide_mask[3:0];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (mem_out.valid) begin
            busy <= 1'b1;
        end else if (mem_in.valid) begin
            busy <= 1'b0;
        end
    end

    assign load_shift = mem_in.rdata >> {offset, 3'b000};

    always_comb begin
        case (dec.funct3)
            3'b000:  load_ext = {{(XLEN-8){load_shift[7]}}, load_shift[7:0]};
            3'b001:  load_ext = {{(XLEN-16){load_shift[15]}}, load_shift[15:0]};
            3'b100:  load_ext = {{(XLEN-8){1'b0}}, load_shift[7:0]};
            3'b101:  load_ext = {{(XLEN-16){1'b0}}, load_shift[15:0]};
            default: load_ext = load_shift;
        endcase
    end

    // Non-memory ops retire on issue, loads and stores on the response
    always_comb begin
        retire.valid = (issue && !(is_load || is_store)) || (busy && mem_in.valid);
        retire.pc    = pc;
        retire.we    = wb_en;
        retire.rd    = dec.rd;
        retire.wdata = is_load ? load_ext : wb_data;
    end

    assign next_pc = next_pc_in;

    a_no_issue_busy: assert property (@(posedge clk) disable iff (reset)
        issue |-> !busy);

endmodule

//--- src/execute/exec_unit.sv
// ALU, branch unit and next PC

`timescale 1ns/10ps

module exec_unit import rv_pkg::*; (
    input  decoded_t        dec,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rdata1,
    input  logic [XLEN-1:0] rdata2,
    output logic [XLEN-1:0] alu_result,
    output logic [XLEN-1:0] wb_data,
    output logic            wb_en,
    output logic [XLEN-1:0] next_pc
);
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] pc_plus4;
    logic            taken;
    logic            is_jump;

    assign pc_plus4 = pc + 4;
    assign is_jump  = dec.opcode == OPC_JAL || dec.opcode == OPC_JALR;

    // I and S types fall through to rs1 + imm
    always_comb begin
        op_a = rdata1;
        op_b = dec.imm;
        case (dec.inst_type)
            TYPE_R:         op_b = rdata2;
            TYPE_U:         op_a = (dec.opcode == OPC_LUI) ? '0 : pc;
            TYPE_J, TYPE_B: op_a = pc;
            default:        ;
        endcase
    end

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << op_b[4:0];
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> op_b[4:0];
            ALU_SRA:  alu_result = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_OR:   alu_result = op_a | op_b;
            default:  alu_result = op_a & op_b;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  taken = rdata1 == rdata2;
            3'b001:  taken = rdata1 != rdata2;
            3'b100:  taken = $signed(rdata1) < $signed(rdata2);
            3'b101:  taken = $signed(rdata1) >= $signed(rdata2);
            3'b110:  taken = rdata1 < rdata2;
            3'b111:  taken = rdata1 >= rdata2;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.opcode)
            OPC_JAL:    next_pc = alu_result;
            OPC_JALR:   next_pc = {alu_result[XLEN-1:1], 1'b0};
            OPC_BRANCH: next_pc = taken ? alu_result : pc_plus4;
            default:    next_pc = pc_plus4;   // Unsupported opcodes too
        endcase
    end

    assign wb_data = is_jump ? pc_plus4 : alu_result;   // Link value for jumps

    always_comb begin
        case (dec.opcode)
            OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_LOAD: wb_en = 1'b1;
            default: wb_en = 1'b0;
        endcase
    end

endmodule

//--- src/decode/inst_decoder.sv
// RV32I instruction decoder

`timescale 1ns/10ps

module inst_decoder import rv_pkg::*; (
    input  inst_u    inst,
    output decoded_t dec
);
    opcode_e         opc;
    inst_type_e      itype;
    logic [XLEN-1:0] imm;
    alu_op_e         aop;

    assign opc = opcode_e'(inst.r.opcode);

    always_comb begin
        case (opc)
            OPC_OP:                         itype = TYPE_R;
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: itype = TYPE_I;
            OPC_STORE:                      itype = TYPE_S;
            OPC_BRANCH:                     itype = TYPE_B;
            OPC_LUI, OPC_AUIPC:             itype = TYPE_U;
            OPC_JAL:                        itype = TYPE_J;
            default:                        itype = TYPE_N;
        endcase
    end

    always_comb begin
        case (itype)
            TYPE_I: imm = {{(XLEN-12){inst.i.imm[11]}}, inst.i.imm};
            TYPE_S: imm = {{(XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            TYPE_B: imm = {{(XLEN-12){inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5,
                           inst.b.imm4_1, 1'b0};
            TYPE_U: imm = {inst.u.imm, 12'b0};
            TYPE_J: imm = {{(XLEN-20){inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11,
                           inst.j.imm10_1, 1'b0};
            default: imm = '0;
        endcase
    end

    // Only OP and OP_IMM pick the ALU op from funct3
    always_comb begin
        aop = ALU_ADD;
        if (opc == OPC_OP || opc == OPC_OP_IMM) begin
            case (inst.r.funct3)
                3'b000: aop = (itype == TYPE_R && inst.r.funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001: aop = ALU_SLL;
                3'b010: aop = ALU_SLT;
                3'b011: aop = ALU_SLTU;
                3'b100: aop = ALU_XOR;
                3'b101: aop = inst.r.funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110: aop = ALU_OR;
                default: aop = ALU_AND;
            endcase
        end
    end

    always_comb begin
        dec.opcode    = opc;
        dec.funct3    = inst.r.funct3;
        dec.rd        = inst.r.rd;
        dec.rs1       = inst.r.rs1;
        dec.rs2       = inst.r.rs2;
        dec.imm       = imm;
        dec.inst_type = itype;
        dec.alu_op    = aop;
    end

endmodule

//--- src/fetch/fetch_unit.sv
// Instruction fetch and PC

`timescale 1ns/10ps

module fetch_unit import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = rv_pkg::RESET_PC
) (
    input  logic            clk,
    input  logic            reset,
    output mem_req_t        fetch_req,
    input  mem_rsp_t        fetch_rsp,
    input  logic            retire_valid,
    input  logic [XLEN-1:0] next_pc,
    output inst_u           inst,
    output logic [XLEN-1:0] pc,
    output logic            issue
);
    typedef enum logic {
        FETCH,
        EXECUTE
    } state_t;

    state_t state;
    logic   boot;   // Kicks the first fetch after reset
    logic   req_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH;
            boot  <= 1'b1;
            req_q <= 1'b0;
            issue <= 1'b0;
            pc    <= RESET_PC;
        end else begin
            boot  <= 1'b0;
            req_q <= boot || (state == EXECUTE && retire_valid);
            issue <= state == FETCH && fetch_rsp.valid;
            case (state)
                FETCH: begin
                    if (fetch_rsp.valid) begin
                        state <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    if (retire_valid) begin
                        state <= FETCH;
                        pc    <= next_pc;
                    end
                end
                default: state <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && fetch_rsp.valid) begin
            inst <= fetch_rsp.rdata;
        end
    end

    always_comb begin
        fetch_req       = '0;   // Read only
        fetch_req.valid = req_q;
        fetch_req.addr  = pc;
    end

    // Retire must belong to the issued instruction
    a_retire_in_exec: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> state == EXECUTE);

endmodule

//--- src/mem_arbiter.sv
// Memory port arbiter

`timescale 1ns/10ps

module mem_arbiter import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  mem_req_t fetch_req,
    output mem_rsp_t fetch_rsp,
    input  mem_req_t data_req,
    output mem_rsp_t data_rsp,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);
    logic outstanding;
    logic owner_data;   // Open request belongs to mem_stage

    assign mem_req = fetch_req.valid ? fetch_req : data_req;   // Fetch wins

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            outstanding <= 1'b0;
            owner_data  <= 1'b0;
        end else if (mem_req.valid) begin
            outstanding <= 1'b1;
            owner_data  <= !fetch_req.valid;
        end else if (mem_rsp.valid) begin
            outstanding <= 1'b0;
        end
    end

    always_comb begin
        fetch_rsp.valid = mem_rsp.valid && outstanding && !owner_data;
        fetch_rsp.rdata = mem_rsp.rdata;
        data_rsp.valid  = mem_rsp.valid && outstanding && owner_data;
        data_rsp.rdata  = mem_rsp.rdata;
    end

    a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
        mem_req.valid |-> !outstanding);

    a_rsp_has_req: assert property (@(posedge clk) disable iff (reset)
        mem_rsp.valid |-> outstanding);

endmodule

//--- src/regfile.sv
// Integer register file

`timescale 1ns/10ps

module regfile import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2,
    input  retire_t               wr
);
    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.we && wr.rd != '0) begin
            regs[wr.rd] <= wr.wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- common/rv_pkg.sv
// RV32I core shared types

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_S,
        TYPE_B,
        TYPE_U,
        TYPE_J,
        TYPE_N  // No operands, retires as no-op
    } inst_type_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, six layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef struct packed {
        opcode_e               opcode;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;      // Sign-extended
        inst_type_e            inst_type;
        alu_op_e               alu_op;
    } decoded_t;

    typedef struct packed {
        logic            valid;
        logic            we;
        logic [XLEN-1:0] addr;   // Word aligned
        logic [XLEN-1:0] wdata;
        logic [3:0]      wmask;
    } mem_req_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       wdata;
    } retire_t;

endpackage
